/* hdl/rename_cfg_pkg.sv */
// register file and commit ring sizes, shared by the rename stage and its testbench
package rename_cfg_pkg;

	// integer architectural registers
	localparam int ARCH_REGS = 32;
	localparam int ARCH_REG_W = 5;

	// commit station ring
	localparam int NCOMMIT = 32;
	localparam int COMMIT_W = 5;

	// must reach NCOMMIT itself, so one bit wider than an index
	localparam int COUNT_W = 6;

	// flag bit over the wider of the two indexes
	localparam int TAG_W = 1 + ((ARCH_REG_W > COMMIT_W) ? ARCH_REG_W : COMMIT_W);

endpackage

/* hdl/rename_types_pkg.sv */
// operand tag layouts and helpers, used by the rename RTL and the testbench model
package rename_types_pkg;

	// flag clear, the value is in the register file
	typedef struct packed {
		logic in_flight;
		// register number, zero extended to the tag width
		logic [rename_cfg_pkg::TAG_W-2:0] arch;
	} arch_ref_t;

	// flag set, the value comes from a commit station
	typedef struct packed {
		logic in_flight;
		logic [rename_cfg_pkg::COMMIT_W-1:0] station;
	} commit_ref_t;

	// the shared top bit says which view holds
	typedef union packed {
		arch_ref_t arch_view;
		commit_ref_t commit_view;
	} operand_tag_t;

	function automatic operand_tag_t make_arch(
		input logic [rename_cfg_pkg::ARCH_REG_W-1:0] r
	);
		operand_tag_t t;
		t.arch_view.in_flight = 1'b0;
		t.arch_view.arch = r;
		return t;
	endfunction

	function automatic operand_tag_t make_commit(
		input logic [rename_cfg_pkg::COMMIT_W-1:0] idx
	);
		operand_tag_t t;
		t.commit_view.in_flight = 1'b1;
		t.commit_view.station = idx;
		return t;
	endfunction

	// tag waits on the station that retires this cycle
	function automatic logic retires(
		input operand_tag_t t,
		input logic retire,
		input logic [rename_cfg_pkg::COMMIT_W-1:0] idx
	);
		return retire && t.commit_view.in_flight && (t.commit_view.station == idx);
	endfunction

endpackage

/* hdl/station_if.sv */
// station allocation, retire and flush events, driven by admission, read by table and output
interface station_if;

	// instruction taken at this edge
	logic accept;
	logic [rename_cfg_pkg::ARCH_REG_W-1:0] rd;
	// makes_rd with a nonzero rd
	logic writes_rd;
	logic [rename_cfg_pkg::COMMIT_W-1:0] alloc_idx;

	// oldest station leaves the ring at this edge
	logic retire;
	logic [rename_cfg_pkg::COMMIT_W-1:0] retire_idx;

	// mispredict or trap, drops everything not yet retired
	logic flush;

	modport admit (
		output accept, rd, writes_rd, alloc_idx,
		output retire, retire_idx, flush
	);

	modport map_table (
		input accept, rd, writes_rd, alloc_idx,
		input retire, retire_idx, flush
	);

	// output stage needs no destination register info from here
	modport issue (
		input accept, alloc_idx, retire, retire_idx, flush
	);

endinterface

/* hdl/rename_admit.sv */
// admission for the rename slot, owns the commit station ring and raises in_ready
module rename_admit (
	input logic clk,
	input logic reset,
	input logic in_valid,
	input logic makes_rd,
	input logic [rename_cfg_pkg::ARCH_REG_W-1:0] rd,
	input logic retire,
	input logic flush,
	input logic out_free,
	output logic in_ready,
	station_if.admit st
);

	logic [rename_cfg_pkg::COMMIT_W-1:0] alloc_ptr;
	logic [rename_cfg_pkg::COMMIT_W-1:0] retire_ptr;
	logic [rename_cfg_pkg::COMMIT_W-1:0] retire_ptr_next;
	logic [rename_cfg_pkg::COUNT_W-1:0] count;
	logic [rename_cfg_pkg::COUNT_W-1:0] count_next;
	logic accept;
	logic do_retire;

	// room in the ring and somewhere to put the result
	assign in_ready = (count < rename_cfg_pkg::NCOMMIT) && out_free;
	assign accept = in_valid && in_ready && !flush;

	// a retire on an empty ring is dropped here
	assign do_retire = retire && (count != '0);
	assign retire_ptr_next = do_retire ? retire_ptr + 1'b1 : retire_ptr;

	always_comb begin
		count_next = count;
		if (accept && !do_retire) begin
			count_next = count + 1'b1;
		end else if (!accept && do_retire) begin
			count_next = count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			alloc_ptr <= '0;
			retire_ptr <= '0;
			count <= '0;
		end else begin
			retire_ptr <= retire_ptr_next;
			if (flush) begin
				// everything younger than the retire point is gone
				alloc_ptr <= retire_ptr_next;
				count <= '0;
			end else begin
				if (accept) begin
					alloc_ptr <= alloc_ptr + 1'b1;
				end
				count <= count_next;
			end
		end
	end

	assign st.accept = accept;
	assign st.rd = rd;
	// x0 is never renamed
	assign st.writes_rd = makes_rd && (rd != '0);
	assign st.alloc_idx = alloc_ptr;
	assign st.retire = do_retire;
	assign st.retire_idx = retire_ptr;
	assign st.flush = flush;

	// count stays within the ring and agrees with the distance between the pointers
	count_in_range: assert property (
		@(posedge clk) disable iff (reset)
		count <= rename_cfg_pkg::NCOMMIT &&
			count[rename_cfg_pkg::COMMIT_W-1:0] == alloc_ptr - retire_ptr
	) else $error("in-flight count out of range or out of step with the ring pointers");

	// commit logic must not retire what was never allocated
	no_retire_when_empty: assert property (
		@(posedge clk) disable iff (reset) retire |-> (count != '0)
	) else $error("retire with no station in flight");

endmodule

/* hdl/rename_map_table.sv */
// latest producer table, turns source registers into operand tags for the rename slot
module rename_map_table (
	input logic clk,
	input logic reset,
	input logic [rename_cfg_pkg::ARCH_REG_W-1:0] rs1,
	input logic [rename_cfg_pkg::ARCH_REG_W-1:0] rs2,
	station_if.map_table st,
	output rename_types_pkg::operand_tag_t src1,
	output rename_types_pkg::operand_tag_t src2
);

	// one tag per architectural register
	rename_types_pkg::operand_tag_t map [rename_cfg_pkg::ARCH_REGS];

	// entry e for register r, as seen by an instruction in this cycle
	function automatic rename_types_pkg::operand_tag_t resolve(
		input logic [rename_cfg_pkg::ARCH_REG_W-1:0] r,
		input rename_types_pkg::operand_tag_t e,
		input logic retire,
		input logic [rename_cfg_pkg::COMMIT_W-1:0] idx
	);
		rename_types_pkg::operand_tag_t t;
		t = e;
		// producer retiring now counts as already in the register file
		if (r == '0 || !e.commit_view.in_flight ||
			rename_types_pkg::retires(e, retire, idx)) begin
			t = rename_types_pkg::make_arch(r);
		end
		return t;
	endfunction

	// lookup happens before this edge's write, so rs == rd sees the older producer
	assign src1 = resolve(rs1, map[rs1], st.retire, st.retire_idx);
	assign src2 = resolve(rs2, map[rs2], st.retire, st.retire_idx);

	always_ff @(posedge clk) begin
		if (reset || st.flush) begin
			for (int i = 0; i < rename_cfg_pkg::ARCH_REGS; i++) begin
				map[i] <= rename_types_pkg::make_arch(i[rename_cfg_pkg::ARCH_REG_W-1:0]);
			end
		end else begin
			for (int i = 0; i < rename_cfg_pkg::ARCH_REGS; i++) begin
				if (rename_types_pkg::retires(map[i], st.retire, st.retire_idx)) begin
					map[i] <= rename_types_pkg::make_arch(
						i[rename_cfg_pkg::ARCH_REG_W-1:0]);
				end
			end
			// new producer wins over a retire clear of the same entry
			if (st.accept && st.writes_rd) begin
				map[st.rd] <= rename_types_pkg::make_commit(st.alloc_idx);
			end
		end
	end

	// x0 qualification lives in admission, the table only trusts it
	x0_stays_arch: assert property (
		@(posedge clk) disable iff (reset) !map[0].commit_view.in_flight
	) else $error("x0 mapped to a commit station");

endmodule

/* hdl/rename_issue_reg.sv */
// output register of the rename slot, holds under back-pressure and wakes sources on retire
module rename_issue_reg (
	input logic clk,
	input logic reset,
	// architectural sources, kept for wake-up
	input logic [rename_cfg_pkg::ARCH_REG_W-1:0] rs1,
	input logic [rename_cfg_pkg::ARCH_REG_W-1:0] rs2,
	input rename_types_pkg::operand_tag_t src1,
	input rename_types_pkg::operand_tag_t src2,
	input logic [rename_cfg_pkg::ARCH_REG_W-1:0] rd,
	input logic out_ready,
	station_if.issue st,
	output logic out_free,
	output logic out_valid,
	output rename_types_pkg::operand_tag_t out_rs1,
	output rename_types_pkg::operand_tag_t out_rs2,
	output logic [rename_cfg_pkg::COMMIT_W-1:0] out_rd_idx,
	output logic [rename_cfg_pkg::ARCH_REG_W-1:0] out_rd
);

	logic [rename_cfg_pkg::ARCH_REG_W-1:0] held_rs1;
	logic [rename_cfg_pkg::ARCH_REG_W-1:0] held_rs2;

	// empty, or being drained this cycle
	assign out_free = !out_valid || out_ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else if (st.flush) begin
			out_valid <= 1'b0;
		end else if (st.accept) begin
			out_valid <= 1'b1;
		end else if (out_ready) begin
			out_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (st.accept) begin
			out_rs1 <= src1;
			out_rs2 <= src2;
			held_rs1 <= rs1;
			held_rs2 <= rs2;
			out_rd_idx <= st.alloc_idx;
			out_rd <= rd;
		end else begin
			// producer left the ring, read the register file instead
			if (rename_types_pkg::retires(out_rs1, st.retire, st.retire_idx)) begin
				out_rs1 <= rename_types_pkg::make_arch(held_rs1);
			end
			if (rename_types_pkg::retires(out_rs2, st.retire, st.retire_idx)) begin
				out_rs2 <= rename_types_pkg::make_arch(held_rs2);
			end
		end
	end

	// in_ready is low while held, so nothing can overwrite a stalled output
	held_output_stable: assert property (
		@(posedge clk) disable iff (reset)
		out_valid && !out_ready && !st.flush |=>
			out_valid && $stable(out_rd_idx) && $stable(out_rd)
	) else $error("held output changed under back-pressure");

endmodule

/* hdl/rename_unit.sv */
// top of the single slot rename stage, joins admission, map table and output register
module rename_unit (
	input logic clk,
	input logic reset,
	// instruction in
	input logic in_valid,
	output logic in_ready,
	input logic [rename_cfg_pkg::ARCH_REG_W-1:0] rs1,
	input logic [rename_cfg_pkg::ARCH_REG_W-1:0] rs2,
	input logic [rename_cfg_pkg::ARCH_REG_W-1:0] rd,
	input logic makes_rd,
	// from commit
	input logic retire,
	input logic flush,
	// renamed instruction out
	output logic out_valid,
	input logic out_ready,
	output rename_types_pkg::operand_tag_t out_rs1,
	output rename_types_pkg::operand_tag_t out_rs2,
	output logic [rename_cfg_pkg::COMMIT_W-1:0] out_rd_idx,
	output logic [rename_cfg_pkg::ARCH_REG_W-1:0] out_rd
);

	logic out_free;
	rename_types_pkg::operand_tag_t src1;
	rename_types_pkg::operand_tag_t src2;

	station_if st ();

	rename_admit u_admit (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.makes_rd(makes_rd),
		.rd(rd),
		.retire(retire),
		.flush(flush),
		.out_free(out_free),
		.in_ready(in_ready),
		.st(st.admit)
	);

	rename_map_table u_table (
		.clk(clk),
		.reset(reset),
		.rs1(rs1),
		.rs2(rs2),
		.st(st.map_table),
		.src1(src1),
		.src2(src2)
	);

	rename_issue_reg u_issue (
		.clk(clk),
		.reset(reset),
		.rs1(rs1),
		.rs2(rs2),
		.src1(src1),
		.src2(src2),
		.rd(rd),
		.out_ready(out_ready),
		.st(st.issue),
		.out_free(out_free),
		.out_valid(out_valid),
		.out_rs1(out_rs1),
		.out_rs2(out_rs2),
		.out_rd_idx(out_rd_idx),
		.out_rd(out_rd)
	);

endmodule

/* tests/tb_clock.sv */
// clock and reset source for the rename testbench, period 8, reset high for 4 cycles
module tb_clock (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial begin
		reset = 1'b1;
		repeat (4) @(posedge clk);
		reset <= 1'b0;
	end

endmodule

/* tests/tb_rename.sv */
// random testbench for the rename stage, checks every cycle against a reference model
module tb_rename;

	localparam int RW = rename_cfg_pkg::ARCH_REG_W;
	localparam int CW = rename_cfg_pkg::COMMIT_W;
	localparam int TW = rename_cfg_pkg::TAG_W;
	localparam int NC = rename_cfg_pkg::NCOMMIT;

	logic clk;
	logic reset;
	logic in_valid;
	logic in_ready;
	logic [RW-1:0] rs1;
	logic [RW-1:0] rs2;
	logic [RW-1:0] rd;
	logic makes_rd;
	logic retire;
	logic flush;
	logic out_valid;
	logic out_ready;
	rename_types_pkg::operand_tag_t out_rs1;
	rename_types_pkg::operand_tag_t out_rs2;
	logic [CW-1:0] out_rd_idx;
	logic [RW-1:0] out_rd;

	// model state
	logic m_inf [rename_cfg_pkg::ARCH_REGS];
	logic [CW-1:0] m_st [rename_cfg_pkg::ARCH_REGS];
	logic [CW-1:0] m_alloc;
	logic [CW-1:0] m_ret;
	int m_count;
	logic e_valid;
	logic [TW-1:0] e_rs1;
	logic [TW-1:0] e_rs2;
	logic [CW-1:0] e_idx;
	logic [RW-1:0] e_rd;
	logic [RW-1:0] e_h1;
	logic [RW-1:0] e_h2;

	// stimulus mix, probabilities out of 16 (flush out of 256)
	int p_valid;
	int p_ready;
	int p_retire;
	int p_flush;
	bit x0_bias;

	logic [31:0] lfsr;
	int errs;
	int total_errs;
	int cycles;
	int tests;
	int t;

	tb_clock u_clock (.clk(clk), .reset(reset));

	rename_unit dut (
		.clk(clk), .reset(reset),
		.in_valid(in_valid), .in_ready(in_ready),
		.rs1(rs1), .rs2(rs2), .rd(rd), .makes_rd(makes_rd),
		.retire(retire), .flush(flush),
		.out_valid(out_valid), .out_ready(out_ready),
		.out_rs1(out_rs1), .out_rs2(out_rs2),
		.out_rd_idx(out_rd_idx), .out_rd(out_rd)
	);

	// fibonacci lfsr, taps 32 22 2 1, one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		logic fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	function automatic logic [RW-1:0] pick_reg();
		if (x0_bias && rand_bits(1)) begin
			return '0;
		end
		return RW'(rand_bits(RW));
	endfunction

	// both views of the tag word
	function automatic string tag_text(input rename_types_pkg::operand_tag_t tg);
		if (tg.commit_view.in_flight) begin
			return $sformatf("station %0d", tg.commit_view.station);
		end
		return $sformatf("x%0d", tg.arch_view.arch);
	endfunction

	function automatic logic [TW-1:0] lookup(input logic [RW-1:0] r, input logic ret);
		if (r == 0 || !m_inf[r] || (ret && m_st[r] == m_ret)) begin
			return {1'b0, r};
		end
		return {1'b1, m_st[r]};
	endfunction

	task automatic model_reset();
		for (int i = 0; i < rename_cfg_pkg::ARCH_REGS; i++) begin
			m_inf[i] = 1'b0;
			m_st[i] = '0;
		end
		m_alloc = '0;
		m_ret = '0;
		m_count = 0;
		e_valid = 1'b0;
	endtask

	// one clock edge of the model, from the inputs applied at this edge
	task automatic model_step();
		logic m_ready;
		logic acc;
		logic ret;
		logic [TW-1:0] s1;
		logic [TW-1:0] s2;
		m_ready = (m_count < NC) && (!e_valid || out_ready);
		acc = in_valid && m_ready && !flush;
		ret = retire && (m_count != 0);
		s1 = lookup(rs1, ret);
		s2 = lookup(rs2, ret);
		if (acc) begin
			e_rs1 = s1;
			e_rs2 = s2;
			e_h1 = rs1;
			e_h2 = rs2;
			e_idx = m_alloc;
			e_rd = rd;
		end else if (ret) begin
			if (e_rs1 == {1'b1, m_ret}) e_rs1 = {1'b0, e_h1};
			if (e_rs2 == {1'b1, m_ret}) e_rs2 = {1'b0, e_h2};
		end
		if (flush) e_valid = 1'b0;
		else if (acc) e_valid = 1'b1;
		else if (out_ready) e_valid = 1'b0;
		if (flush) begin
			for (int i = 0; i < rename_cfg_pkg::ARCH_REGS; i++) m_inf[i] = 1'b0;
		end else begin
			for (int i = 0; i < rename_cfg_pkg::ARCH_REGS; i++) begin
				if (ret && m_inf[i] && m_st[i] == m_ret) m_inf[i] = 1'b0;
			end
			if (acc && makes_rd && rd != 0) begin
				m_inf[rd] = 1'b1;
				m_st[rd] = m_alloc;
			end
		end
		if (ret) m_ret = m_ret + 1'b1;
		if (flush) begin
			m_alloc = m_ret;
			m_count = 0;
		end else begin
			if (acc) m_alloc = m_alloc + 1'b1;
			m_count = m_count + (acc ? 1 : 0) - (ret ? 1 : 0);
		end
	endtask

	task automatic drive_inputs();
		in_valid <= rand_bits(4) < p_valid;
		rs1 <= pick_reg();
		rs2 <= pick_reg();
		rd <= pick_reg();
		makes_rd <= rand_bits(1) != 0;
		out_ready <= rand_bits(4) < p_ready;
		// never retire an empty ring
		retire <= (m_count > 0) && (rand_bits(4) < p_retire);
		flush <= rand_bits(8) < p_flush;
	endtask

	task automatic check_outputs();
		logic exp_ready;
		exp_ready = (m_count < NC) && (!e_valid || out_ready);
		if (in_ready !== exp_ready) begin
			$display("ERR %0t: in_ready %b expected %b", $time, in_ready, exp_ready);
			errs++;
		end
		if (out_valid !== e_valid) begin
			$display("ERR %0t: out_valid %b expected %b", $time, out_valid, e_valid);
			errs++;
		end
		if (e_valid && out_valid) begin
			if (out_rs1 !== e_rs1) begin
				$display("ERR %0t: out_rs1 %s expected %s", $time,
					tag_text(out_rs1), tag_text(e_rs1));
				errs++;
			end
			if (out_rs2 !== e_rs2) begin
				$display("ERR %0t: out_rs2 %s expected %s", $time,
					tag_text(out_rs2), tag_text(e_rs2));
				errs++;
			end
			if (out_rd_idx !== e_idx || out_rd !== e_rd) begin
				$display("ERR %0t: rd x%0d station %0d expected x%0d station %0d",
					$time, out_rd, out_rd_idx, e_rd, e_idx);
				errs++;
			end
		end
	endtask

	task automatic cycle();
		@(posedge clk);
		model_step();
		drive_inputs();
		@(negedge clk);
		check_outputs();
		cycles++;
	endtask

	task automatic set_mix(input int v, input int r, input int ret, input int fl, input bit x0);
		p_valid = v;
		p_ready = r;
		p_retire = ret;
		p_flush = fl;
		x0_bias = x0;
	endtask

	task automatic run_test(input string name, input int n);
		errs = 0;
		for (int i = 0; i < n; i++) cycle();
		report(name);
	endtask

	task automatic report(input string name);
		$display("test %s: %0d errors", name, errs);
		total_errs += errs;
		tests++;
	endtask

	initial begin
		lfsr = 32'd84142;
		in_valid = 1'b0;
		rs1 = '0;
		rs2 = '0;
		rd = '0;
		makes_rd = 1'b0;
		retire = 1'b0;
		flush = 1'b0;
		out_ready = 1'b0;
		total_errs = 0;
		cycles = 0;
		tests = 0;
		model_reset();
		set_mix(0, 16, 0, 0, 1'b0);

		t = 0;
		@(negedge clk);
		while (reset && t < 20) begin
			@(negedge clk);
			t++;
		end
		if (reset) begin
			$display("reset never released");
			total_errs++;
		end

		set_mix(12, 14, 0, 0, 1'b0);
		run_test("rename_no_retire", 60);
		set_mix(10, 12, 8, 0, 1'b0);
		run_test("retire_wakeup", 600);
		set_mix(12, 4, 6, 0, 1'b0);
		run_test("back_pressure", 600);

		// full ring, empty it first with a flush
		errs = 0;
		set_mix(0, 16, 0, 256, 1'b0);
		cycle();
		set_mix(16, 16, 0, 0, 1'b0);
		t = 0;
		while (in_ready && t < 100) begin
			cycle();
			t++;
		end
		if (in_ready) begin
			$display("in_ready never dropped with the ring filling");
			errs++;
		end else if (m_count != NC) begin
			$display("ERR %0t: in_ready low with %0d in flight", $time, m_count);
			errs++;
		end
		set_mix(16, 16, 16, 0, 1'b0);
		cycle();
		set_mix(0, 16, 0, 0, 1'b0);
		t = 0;
		while (!in_ready && t < 10) begin
			cycle();
			t++;
		end
		if (!in_ready) begin
			$display("in_ready stayed low after a retire");
			errs++;
		end
		report("full_ring");

		set_mix(12, 12, 6, 24, 1'b0);
		run_test("flush", 600);
		set_mix(12, 12, 6, 2, 1'b1);
		run_test("x0_mapping", 400);

		$display("%0d tests, %0d cycles, %0d errors", tests, cycles, total_errs);
		if (total_errs == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

/* project.f */
hdl/rename_cfg_pkg.sv
hdl/rename_types_pkg.sv
hdl/station_if.sv
hdl/rename_admit.sv
hdl/rename_map_table.sv
hdl/rename_issue_reg.sv
hdl/rename_unit.sv
tests/tb_clock.sv
tests/tb_rename.sv

/* run.sh */
#!/bin/sh
# build and run the rename testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -f project.f --top-module tb_rename -o sim_rename
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

./obj_dir/sim_rename > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^sim passed$" sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1
